//--- uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial line timing, all counts in clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Bit period on both tx and rx
`define UART_CLKS_PER_BIT 16

// Idle high time between header and data frame of a write
`define UART_GAP_CYCLES 32

// Deadline for the reply start bit, counted after the last
// transmitted stop bit
`define UART_RSP_TIMEOUT 600

`endif

//--- uart_pkg.sv
package uart_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } uart_op_e;

  typedef enum logic [1:0] {
    RSP_OK         = 2'd0,
    RSP_PARITY_ERR = 2'd1,
    RSP_FRAME_ERR  = 2'd2,
    RSP_TIMEOUT    = 2'd3
  } rsp_status_e;

  typedef enum logic [2:0] {
    SEQ_IDLE      = 3'd0,
    SEQ_SEND_HDR  = 3'd1,
    SEQ_GAP       = 3'd2,
    SEQ_SEND_DATA = 3'd3,
    SEQ_WAIT_RSP  = 3'd4,
    SEQ_HOLD_RSP  = 3'd5
  } seq_state_e;

  // Opcode lands in bit 7 of the header byte
  typedef struct packed {
    uart_op_e   op;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  typedef struct packed {
    rsp_status_e status;
    logic [7:0]  data;
  } uart_rsp_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_frame_t;

endpackage

//--- uart_tx.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx_done,
  output logic       tx
);

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);
  // Start bit is index 0, stop bit index 10
  localparam logic [3:0] STOP_IDX = 4'd10;

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  // Bits still to go out after the start bit: stop, parity, data
  logic [9:0]       shreg;
  logic             bit_end;

  assign bit_end  = busy && (clk_cnt == CNT_LAST);
  assign tx_done  = bit_end && (bit_cnt == STOP_IDX);
  assign tx_ready = !busy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit timing and line drive
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end
    else if (!busy)
    begin
      // Start bit goes out on the accepting edge
      if (tx_valid)
      begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
        tx      <= 1'b0;
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (bit_cnt == STOP_IDX)
      begin
        busy <= 1'b0;
      end
      else
      begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Odd parity over data plus parity bit
  always_ff @(posedge clk)
  begin
    if (!busy && tx_valid)
    begin
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (bit_end)
    begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_rx
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rx,
  output rx_frame_t rx_frame,
  output logic      rx_frame_valid
);

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CPB / 2 - 1);
  localparam logic [3:0] PAR_IDX  = 4'd9;
  localparam logic [3:0] STOP_IDX = 4'd10;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       data_sh;
  logic             par_bit;
  logic             fall;
  logic             sample;

  assign fall = !busy && rx_prev && !rx_sync;

  // Start bit checked at half a period, the rest at mid-bit
  assign sample = busy && ((bit_idx == 4'd0) ? (clk_cnt == CNT_HALF)
                                             : (clk_cnt == CNT_LAST));

  // Line idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy           <= 1'b0;
      clk_cnt        <= '0;
      bit_idx        <= '0;
      rx_frame_valid <= 1'b0;
    end
    else
    begin
      rx_frame_valid <= 1'b0;
      if (fall)
      begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
      else if (sample)
      begin
        clk_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync)
        begin
          // Glitch, not a start bit
          busy <= 1'b0;
        end
        else if (bit_idx == STOP_IDX)
        begin
          busy           <= 1'b0;
          rx_frame_valid <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else if (busy)
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == PAR_IDX)
      begin
        par_bit <= rx_sync;
      end
      else if (bit_idx == STOP_IDX)
      begin
        rx_frame.data      <= data_sh;
        rx_frame.parity_ok <= ^{data_sh, par_bit};
        rx_frame.stop_ok   <= rx_sync;
      end
      else if (bit_idx != 4'd0)
      begin
        data_sh <= {rx_sync, data_sh[7:1]};
      end
    end
  end

endmodule

//--- uart_cmd_seq.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_cmd_seq
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output logic [7:0] tx_byte,
  output logic       tx_valid,
  input  logic       tx_ready,
  input  logic       tx_done,
  input  rx_frame_t  rx_frame,
  input  logic       rx_frame_valid,
  output uart_rsp_t  rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready
);

  localparam int GAP = `UART_GAP_CYCLES;
  // Reply window plus one frame, so a start late in the window still completes
  localparam int WAIT_LIMIT = `UART_RSP_TIMEOUT + 11 * `UART_CLKS_PER_BIT;
  localparam int CNT_MAX = (WAIT_LIMIT > GAP) ? WAIT_LIMIT : GAP;
  localparam int CNT_W = $clog2(CNT_MAX + 1);
  localparam logic [CNT_W-1:0] GAP_LAST  = CNT_W'(GAP - 1);
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_LIMIT - 1);

  seq_state_e       state;
  uart_cmd_t        cmd_q;
  logic [CNT_W-1:0] cnt;
  rsp_status_e      rx_status;

  assign cmd_ready = (state == SEQ_IDLE);
  assign rsp_valid = (state == SEQ_HOLD_RSP);
  assign tx_byte   = (state == SEQ_SEND_DATA) ? cmd_q.data : {cmd_q.op, cmd_q.addr};

  // Parity error outranks a bad stop bit
  always_comb
  begin
    if (!rx_frame.parity_ok)
      rx_status = RSP_PARITY_ERR;
    else if (!rx_frame.stop_ok)
      rx_status = RSP_FRAME_ERR;
    else
      rx_status = RSP_OK;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      tx_valid <= 1'b0;
      cnt      <= '0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          if (cmd_valid)
          begin
            tx_valid <= 1'b1;
            state    <= SEQ_SEND_HDR;
          end
        end
        SEQ_SEND_HDR:
        begin
          if (tx_ready)
            tx_valid <= 1'b0;
          if (tx_done)
          begin
            cnt   <= '0;
            state <= (cmd_q.op == OP_WRITE) ? SEQ_GAP : SEQ_WAIT_RSP;
          end
        end
        SEQ_GAP:
        begin
          if (cnt == GAP_LAST)
          begin
            tx_valid <= 1'b1;
            state    <= SEQ_SEND_DATA;
          end
          else
            cnt <= cnt + 1'b1;
        end
        SEQ_SEND_DATA:
        begin
          if (tx_ready)
            tx_valid <= 1'b0;
          if (tx_done)
            state <= SEQ_IDLE;
        end
        SEQ_WAIT_RSP:
        begin
          if (rx_frame_valid || cnt == WAIT_LAST)
            state <= SEQ_HOLD_RSP;
          else
            cnt <= cnt + 1'b1;
        end
        SEQ_HOLD_RSP:
        begin
          if (rsp_ready)
            state <= SEQ_IDLE;
        end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_ready && cmd_valid)
      cmd_q <= cmd;
    if (state == SEQ_WAIT_RSP)
    begin
      if (rx_frame_valid)
      begin
        rsp.status <= rx_status;
        rsp.data   <= (rx_status == RSP_OK) ? rx_frame.data : 8'h00;
      end
      else if (cnt == WAIT_LAST)
      begin
        rsp.status <= RSP_TIMEOUT;
        rsp.data   <= 8'h00;
      end
    end
  end

endmodule

//--- uart_master_top.sv
`timescale 1ns/10ps

module uart_master_top
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  uart_cmd_t cmd,
  input  logic      cmd_valid,
  output logic      cmd_ready,
  output uart_rsp_t rsp,
  output logic      rsp_valid,
  input  logic      rsp_ready,
  output logic      tx,
  input  logic      rx
);

  logic [7:0] tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  logic       tx_done;
  rx_frame_t  rx_frame;
  logic       rx_frame_valid;

  uart_cmd_seq u_cmd_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .tx_byte        (tx_byte),
    .tx_valid       (tx_valid),
    .tx_ready       (tx_ready),
    .tx_done        (tx_done),
    .rx_frame       (rx_frame),
    .rx_frame_valid (rx_frame_valid),
    .rsp            (rsp),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx u_rx (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx             (rx),
    .rx_frame       (rx_frame),
    .rx_frame_valid (rx_frame_valid)
  );

endmodule

//--- uart_master_checker.sv
`timescale 1ns/10ps

module uart_master_checker
  import uart_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input uart_rsp_t  rsp,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input logic       cmd_ready,
  input logic       tx,
  input seq_state_e seq_state
);

  int failures = 0;

  // Response held while the host stalls
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
  else
  begin
    $error("response changed while stalled");
    failures++;
  end

  // Command port reopens the cycle after the response is taken
  cmd_after_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |=> cmd_ready && !rsp_valid)
  else
  begin
    $error("cmd_ready not back after the response handshake");
    failures++;
  end

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    seq_state == SEQ_IDLE |-> tx)
  else
  begin
    $error("tx low while the sequencer is idle");
    failures++;
  end

endmodule

bind uart_master_top uart_master_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .rsp       (rsp),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .cmd_ready (cmd_ready),
  .tx        (tx),
  .seq_state (u_cmd_seq.state)
);

//--- tb_uart_master.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module tb_uart_master
  import uart_pkg::*;
();

  localparam int CPB       = `UART_CLKS_PER_BIT;
  localparam int GAP       = `UART_GAP_CYCLES;
  localparam int NUM_TESTS = 60;
  // Two frames plus gap plus reply window, in cycles
  localparam int CMD_WORST   = 2 * 11 * CPB + GAP + `UART_RSP_TIMEOUT;
  localparam int WATCHDOG_NS = NUM_TESTS * CMD_WORST * 8 * 2;

  logic      clk;
  logic      rst_n;
  uart_cmd_t cmd;
  logic      cmd_valid;
  logic      cmd_ready;
  uart_rsp_t rsp;
  logic      rsp_valid;
  logic      rsp_ready;
  logic      tx;
  logic      rx;

  logic [31:0] rng_state;
  logic [7:0]  regs [0:127];
  logic        rsp_valid_q;
  int          cycle = 0;
  int          errors = 0;
  int          read_count = 0;
  int          rsp_count = 0;
  int          passed = 0;
  int          failed = 0;

  uart_master_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .tx        (tx),
    .rx        (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  // Responses offered by the DUT, counted on the rising edge of rsp_valid
  always @(posedge clk)
  begin
    if (!rst_n)
      rsp_valid_q <= 1'b0;
    else
    begin
      rsp_valid_q <= rsp_valid;
      if (rsp_valid && !rsp_valid_q)
        rsp_count <= rsp_count + 1;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic note_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side and remote device model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_command(input uart_cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    while (!cmd_ready)
      @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // Samples tx at mid-bit, LSB first
  task automatic receive_frame(output logic [7:0] data, output int fall_cycle);
    logic par;
    logic stop;
    int   i;
    while (tx)
      @(negedge clk);
    fall_cycle = cycle;
    repeat (CPB / 2) @(negedge clk);
    assert (!tx) else note_mismatch("start bit high at mid-bit");
    for (i = 0; i < 8; i++)
    begin
      repeat (CPB) @(negedge clk);
      data[i] = tx;
    end
    repeat (CPB) @(negedge clk);
    par = tx;
    repeat (CPB) @(negedge clk);
    stop = tx;
    assert (^{data, par}) else note_mismatch($sformatf("even parity on byte %02h", data));
    assert (stop) else note_mismatch("stop bit low");
  endtask

  task automatic send_reply(input logic [7:0] data, input logic bad_parity,
                            input logic bad_stop);
    logic [10:0] frame;
    int          i;
    frame = {~bad_stop, bad_parity ^ ~^data, data, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      rx = frame[i];
      repeat (CPB) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic take_response(input rsp_status_e exp_status, input logic [7:0] exp_data);
    uart_rsp_t got;
    int        stall;
    while (!rsp_valid)
      @(negedge clk);
    got = rsp;
    assert (got.status == exp_status && got.data == exp_data)
    else note_mismatch($sformatf("rsp %0d/%02h, expected %0d/%02h",
                                 got.status, got.data, exp_status, exp_data));
    stall = int'(next_random() % 6);
    repeat (stall)
    begin
      assert (rsp_valid && rsp == got && !cmd_ready)
      else note_mismatch("response or cmd_ready changed during stall");
      @(negedge clk);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    assert (!rsp_valid && cmd_ready) else note_mismatch("response not retired after handshake");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    uart_cmd_t   c;
    logic [31:0] r;
    logic [7:0]  hdr;
    logic [7:0]  dat;
    int          fall_hdr;
    int          fall_dat;
    int          kind;
    int          err_before;
    int          t;
    int          i;

    rng_state = 32'd14070;
    rst_n     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    rsp_ready = 1'b0;
    rx        = 1'b1;
    for (i = 0; i < 128; i++)
      regs[i] = 8'(i * 13 + 33);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx && !rsp_valid && cmd_ready) else note_mismatch("idle outputs wrong after reset");
    if (errors == 0)
      passed++;
    else
      failed++;
    $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");

    for (t = 0; t < NUM_TESTS; t++)
    begin
      err_before = errors;
      r = next_random();
      c.op   = (t == 0) ? OP_WRITE : (t < 5) ? OP_READ : uart_op_e'(r[0]);
      // Half the commands hit a few low addresses so reads see earlier writes
      c.addr = r[20] ? {4'b0000, r[3:1]} : r[7:1];
      c.data = r[15:8];
      // 0 clean reply, 1 bad parity, 2 low stop, 3 silent
      kind = (t >= 1 && t < 5) ? t - 1 : (r[18:16] < 3'd5) ? 0 : int'(r[18:16]) - 4;
      repeat (r[23:21]) @(negedge clk);
      send_command(c);
      receive_frame(hdr, fall_hdr);
      assert (hdr == {c.op, c.addr})
      else note_mismatch($sformatf("header %02h, expected %02h", hdr, {c.op, c.addr}));
      if (c.op == OP_WRITE)
      begin
        receive_frame(dat, fall_dat);
        assert (dat == c.data)
        else note_mismatch($sformatf("data byte %02h, expected %02h", dat, c.data));
        assert (fall_dat - fall_hdr - 11 * CPB >= GAP)
        else note_mismatch($sformatf("gap of %0d cycles", fall_dat - fall_hdr - 11 * CPB));
        regs[hdr[6:0]] = dat;
        while (!cmd_ready)
        begin
          assert (!rsp_valid) else note_mismatch("response after a write");
          @(negedge clk);
        end
      end
      else
      begin
        read_count++;
        if (kind != 3)
        begin
          repeat (8 + next_random() % 392) @(negedge clk);
          send_reply(regs[hdr[6:0]], kind == 1, kind == 2);
        end
        case (kind)
          0:       take_response(RSP_OK, regs[hdr[6:0]]);
          1:       take_response(RSP_PARITY_ERR, 8'h00);
          2:       take_response(RSP_FRAME_ERR, 8'h00);
          default: take_response(RSP_TIMEOUT, 8'h00);
        endcase
      end
      if (errors == err_before)
        passed++;
      else
        failed++;
      $display("test %0d %s addr %02h reply %0d: %s", t,
               (c.op == OP_WRITE) ? "write" : "read", c.addr, kind,
               (errors == err_before) ? "ok" : "FAILED");
    end

    assert (rsp_count == read_count)
    else note_mismatch($sformatf("%0d responses for %0d reads", rsp_count, read_count));
    assert (uut.u_checker.failures == 0)
    else
    begin
      $display("The handshake checker saw %0d assertion failures", uut.u_checker.failures);
      errors++;
    end
    $display("summary: %0d passed, %0d failed, %0d mismatches", passed, failed, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_seq.sv
uart_master_top.sv
uart_master_checker.sv
tb_uart_master.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_uart_master
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
